// ==== hog_pkg.sv ====
`default_nettype none

package hog_pkg;

	// pixel and tile geometry
	localparam int PIX_W     = 8;
	localparam int BLK_DIM   = 3;
	localparam int BLOCKS    = 4;
	localparam int BLK_PIX   = BLK_DIM * BLK_DIM;
	localparam int TILE_ROWS = BLK_DIM;
	localparam int TILE_COLS = BLK_DIM * BLOCKS;

	// arithmetic widths
	localparam int GRAD_W    = PIX_W + 1;
	localparam int MAG_W     = 2 * PIX_W + 1;
	localparam int ROW_CNT_W = 8;

	typedef logic [PIX_W-1:0] pixel_t;
	typedef logic signed [GRAD_W-1:0] grad_t;
	typedef logic [MAG_W-1:0] mag_t;

	// index 0 is the leftmost column
	typedef pixel_t [TILE_COLS-1:0] tile_row_t;

	// index 0 is the top row
	typedef pixel_t [TILE_ROWS-1:0] tile_col_t;

	// [row][column], row 0 on top, column 0 on the left
	typedef grad_t [TILE_ROWS-1:0][TILE_COLS-1:0] grad_tile_t;

	// byte 8 is top left, byte 0 bottom right, row major
	typedef pixel_t [BLK_PIX-1:0] blk_word_t;

	// same position order as blk_word_t
	typedef mag_t [BLK_PIX-1:0] mag_word_t;

endpackage

`default_nettype wire

// ==== hog_line_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hog_line_if #(
	parameter int LINE_TILES = 53
);

	localparam int COL_W = $clog2(LINE_TILES);

	// request side, from the gradient stage
	logic [COL_W-1:0]   rd_col;
	hog_pkg::tile_row_t wr_row;
	hog_pkg::tile_col_t wr_col;

	// saved context, from the store
	hog_pkg::tile_row_t above_row;
	hog_pkg::tile_col_t left_col;

	modport store (
		input  rd_col,
		input  wr_row,
		input  wr_col,
		output above_row,
		output left_col
	);

	modport user (
		output rd_col,
		output wr_row,
		output wr_col,
		input  above_row,
		input  left_col
	);

endinterface

`default_nettype wire

// ==== hog_grad_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface hog_grad_if;

	// registered differences, one per tile pixel
	hog_pkg::grad_tile_t gx;
	hog_pkg::grad_tile_t gy;

	modport src (
		output gx,
		output gy
	);

	modport dst (
		input gx,
		input gy
	);

endinterface

`default_nettype wire

// ==== hog_line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module hog_line_store #(
	parameter int LINE_TILES = 53
)(
	input  logic       clk,
	input  logic       rst_n,
	hog_line_if.store  line
);

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	// bottom row of the last tile seen at each tile column
	hog_pkg::tile_row_t row_mem [LINE_TILES];

	// right column of the previous tile in this strip
	hog_pkg::tile_col_t col_q;

	////////////////////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////////////////////

	// read is combinational so the current tile sees the row
	// written one strip earlier, before this edge overwrites it
	assign line.above_row = row_mem[line.rd_col];
	assign line.left_col  = col_q;

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < LINE_TILES; i++) begin
				row_mem[i] <= '0;
			end
			col_q <= '0;
		end else begin
			// a tile arrives every cycle, so both stores update every edge
			row_mem[line.rd_col] <= line.wr_row;
			col_q                <= line.wr_col;
		end
	end

endmodule

`default_nettype wire

// ==== hog_gradient.sv ====
`timescale 1ns/1ps
`default_nettype none

module hog_gradient #(
	parameter int LINE_TILES = 53
)(
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [hog_pkg::ROW_CNT_W-1:0]    cnt_row,
	input  logic [$clog2(LINE_TILES)-1:0]    cnt_col,
	input  hog_pkg::blk_word_t               block0,
	input  hog_pkg::blk_word_t               block1,
	input  hog_pkg::blk_word_t               block2,
	input  hog_pkg::blk_word_t               block3,
	hog_line_if.user                         line,
	hog_grad_if.src                          grad
);

	localparam int ROWS = hog_pkg::TILE_ROWS;
	localparam int COLS = hog_pkg::TILE_COLS;
	localparam int DIM  = hog_pkg::BLK_DIM;

	hog_pkg::blk_word_t blk [hog_pkg::BLOCKS];

	// tile as rows of pixels, row 0 on top
	hog_pkg::tile_row_t [ROWS-1:0] pix;

	// neighbour operands for every pixel
	hog_pkg::tile_row_t [ROWS-1:0] left_nb;
	hog_pkg::tile_row_t [ROWS-1:0] up_nb;

	// difference of two unsigned pixels, range -255..255
	function automatic hog_pkg::grad_t pix_diff(
		input hog_pkg::pixel_t a,
		input hog_pkg::pixel_t b
	);
		return hog_pkg::grad_t'({1'b0, a}) - hog_pkg::grad_t'({1'b0, b});
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// unpack the four blocks into a 3x12 tile
	////////////////////////////////////////////////////////////////////////////

	assign blk[0] = block0;
	assign blk[1] = block1;
	assign blk[2] = block2;
	assign blk[3] = block3;

	always_comb begin
		for (int b = 0; b < hog_pkg::BLOCKS; b++) begin
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < DIM; c++) begin
					// byte 8 is top left of the block
					pix[r][b*DIM+c] = blk[b][hog_pkg::BLK_PIX-1-(r*DIM+c)];
				end
			end
		end
	end

	// context for the next tile column and the next strip
	assign line.rd_col = cnt_col;
	assign line.wr_row = pix[ROWS-1];

	always_comb begin
		for (int r = 0; r < ROWS; r++) begin
			line.wr_col[r] = pix[r][COLS-1];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// neighbour selection
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int r = 0; r < ROWS; r++) begin
			// column 0 borrows from the previous tile, zero at the image edge
			left_nb[r][0] = (cnt_col == '0) ? '0 : line.left_col[r];
			for (int c = 1; c < COLS; c++) begin
				left_nb[r][c] = pix[r][c-1];
			end
		end
		for (int c = 0; c < COLS; c++) begin
			// top row borrows from the previous strip
			up_nb[0][c] = (cnt_row == '0) ? '0 : line.above_row[c];
		end
		for (int r = 1; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				up_nb[r][c] = pix[r-1][c];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// difference stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			grad.gx <= '0;
			grad.gy <= '0;
		end else begin
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < COLS; c++) begin
					grad.gx[r][c] <= pix_diff(pix[r][c], left_nb[r][c]);
					grad.gy[r][c] <= pix_diff(pix[r][c], up_nb[r][c]);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hog_magnitude.sv ====
`timescale 1ns/1ps
`default_nettype none

module hog_magnitude (
	input  logic                clk,
	input  logic                rst_n,
	hog_grad_if.dst             grad,
	output hog_pkg::mag_word_t  hog_out0,
	output hog_pkg::mag_word_t  hog_out1,
	output hog_pkg::mag_word_t  hog_out2,
	output hog_pkg::mag_word_t  hog_out3
);

	localparam int ROWS = hog_pkg::TILE_ROWS;
	localparam int COLS = hog_pkg::TILE_COLS;
	localparam int DIM  = hog_pkg::BLK_DIM;

	hog_pkg::mag_t [ROWS-1:0][COLS-1:0] sq_x;
	hog_pkg::mag_t [ROWS-1:0][COLS-1:0] sq_y;

	// one packed word per block
	hog_pkg::mag_word_t sum_w [hog_pkg::BLOCKS];

	// at most 255^2, so the low bits of the wide product hold it exactly
	function automatic hog_pkg::mag_t square(input hog_pkg::grad_t g);
		logic signed [hog_pkg::MAG_W-1:0] wide;
		wide = g;
		return hog_pkg::mag_t'(wide * wide);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// square stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sq_x <= '0;
			sq_y <= '0;
		end else begin
			for (int r = 0; r < ROWS; r++) begin
				for (int c = 0; c < COLS; c++) begin
					sq_x[r][c] <= square(grad.gx[r][c]);
					sq_y[r][c] <= square(grad.gy[r][c]);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// sum stage, packed straight into block order
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < hog_pkg::BLOCKS; k++) begin
				sum_w[k] <= '0;
			end
		end else begin
			for (int k = 0; k < hog_pkg::BLOCKS; k++) begin
				for (int r = 0; r < ROWS; r++) begin
					for (int c = 0; c < DIM; c++) begin
						sum_w[k][hog_pkg::BLK_PIX-1-(r*DIM+c)] <=
							sq_x[r][k*DIM+c] + sq_y[r][k*DIM+c];
					end
				end
			end
		end
	end

	// word k covers tile columns 3k..3k+2
	assign hog_out0 = sum_w[0];
	assign hog_out1 = sum_w[1];
	assign hog_out2 = sum_w[2];
	assign hog_out3 = sum_w[3];

endmodule

`default_nettype wire

// ==== hog_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hog_top #(
	// image width in tiles
	parameter int LINE_TILES = 53
)(
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [hog_pkg::ROW_CNT_W-1:0]    cnt_row,
	input  logic [$clog2(LINE_TILES)-1:0]    cnt_col,
	input  hog_pkg::blk_word_t               block0,
	input  hog_pkg::blk_word_t               block1,
	input  hog_pkg::blk_word_t               block2,
	input  hog_pkg::blk_word_t               block3,
	output hog_pkg::mag_word_t               hog_out0,
	output hog_pkg::mag_word_t               hog_out1,
	output hog_pkg::mag_word_t               hog_out2,
	output hog_pkg::mag_word_t               hog_out3
);

	////////////////////////////////////////////////////////////////////////////
	// internal links
	////////////////////////////////////////////////////////////////////////////

	hog_line_if #(
		.LINE_TILES (LINE_TILES)
	) line_if ();

	hog_grad_if grad_if ();

	////////////////////////////////////////////////////////////////////////////
	// pipeline
	////////////////////////////////////////////////////////////////////////////

	// differences registered one edge after the tile is sampled
	hog_gradient #(
		.LINE_TILES (LINE_TILES)
	) i_gradient (
		.clk     (clk),
		.rst_n   (rst_n),
		.cnt_row (cnt_row),
		.cnt_col (cnt_col),
		.block0  (block0),
		.block1  (block1),
		.block2  (block2),
		.block3  (block3),
		.line    (line_if.user),
		.grad    (grad_if.src)
	);

	// bottom rows per tile column plus the previous right column
	hog_line_store #(
		.LINE_TILES (LINE_TILES)
	) i_line_store (
		.clk   (clk),
		.rst_n (rst_n),
		.line  (line_if.store)
	);

	// squares then sums, outputs valid three edges after sampling
	hog_magnitude i_magnitude (
		.clk      (clk),
		.rst_n    (rst_n),
		.grad     (grad_if.dst),
		.hog_out0 (hog_out0),
		.hog_out1 (hog_out1),
		.hog_out2 (hog_out2),
		.hog_out3 (hog_out3)
	);

endmodule

`default_nettype wire

// ==== tb_hog.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hog;

	localparam int LINE_TILES  = 4;
	localparam int COL_W       = $clog2(LINE_TILES);
	localparam int DIM         = hog_pkg::BLK_DIM;
	localparam int BLOCKS      = hog_pkg::BLOCKS;
	localparam int MAX_STRIPS  = 3;
	localparam int IMG_W       = LINE_TILES * hog_pkg::TILE_COLS;
	localparam int RAND_IMAGES = 6;
	localparam int LATENCY     = 3;
	localparam int PERIOD      = 40;

	// reset, single tile, one strip, two strips, two images, random images
	localparam int TOTAL_TILES = (5 + LATENCY) + (1 + LATENCY) + (LINE_TILES + LATENCY)
		+ (2 * LINE_TILES + LATENCY) + (4 * LINE_TILES + LATENCY)
		+ (RAND_IMAGES * MAX_STRIPS * LINE_TILES + LATENCY);

	typedef hog_pkg::mag_word_t [BLOCKS-1:0] out_set_t;

	logic                          clk;
	logic                          rst_n;
	logic [hog_pkg::ROW_CNT_W-1:0] cnt_row;
	logic [COL_W-1:0]              cnt_col;
	hog_pkg::blk_word_t            block0;
	hog_pkg::blk_word_t            block1;
	hog_pkg::blk_word_t            block2;
	hog_pkg::blk_word_t            block3;
	hog_pkg::mag_word_t            hog_out0;
	hog_pkg::mag_word_t            hog_out1;
	hog_pkg::mag_word_t            hog_out2;
	hog_pkg::mag_word_t            hog_out3;

	// whole image for the reference model, row 0 on top
	logic [7:0] img [MAX_STRIPS*DIM][IMG_W];

	// expected words of the tiles in flight, oldest first
	out_set_t exp_q [$];

	int err_count;
	int pass_count;
	int fail_count;

	hog_top #(
		.LINE_TILES (LINE_TILES)
	) i_dut (
		.clk      (clk),
		.rst_n    (rst_n),
		.cnt_row  (cnt_row),
		.cnt_col  (cnt_col),
		.block0   (block0),
		.block1   (block1),
		.block2   (block2),
		.block3   (block3),
		.hog_out0 (hog_out0),
		.hog_out1 (hog_out1),
		.hog_out2 (hog_out2),
		.hog_out3 (hog_out3)
	);

	initial clk = 1'b0;
	always #(PERIOD/2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [7:0] random_pixel();
		int unsigned v;
		v = $urandom;
		// extremes now and then to reach the widest sums
		case (v % 8)
			0: return 8'h00;
			1: return 8'hff;
			default: return v[15:8];
		endcase
	endfunction

	// left and upper neighbours, zero outside the image
	function automatic out_set_t expected_tile(input int s, input int c);
		out_set_t w;
		int y;
		int x;
		int p;
		int left;
		int up;
		w = '0;
		for (int k = 0; k < BLOCKS; k++) begin
			for (int r = 0; r < DIM; r++) begin
				for (int cc = 0; cc < DIM; cc++) begin
					y = DIM * s + r;
					x = hog_pkg::TILE_COLS * c + DIM * k + cc;
					p = img[y][x];
					left = (x == 0) ? 0 : img[y][x-1];
					up = (y == 0) ? 0 : img[y-1][x];
					w[k][8-(r*DIM+cc)] = (p - left) * (p - left) + (p - up) * (p - up);
				end
			end
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus and checking
	////////////////////////////////////////////////////////////////////////////

	task automatic check_outputs();
		out_set_t want;
		out_set_t got;
		want = exp_q.pop_front();
		got = {hog_out3, hog_out2, hog_out1, hog_out0};
		for (int k = 0; k < BLOCKS; k++) begin
			assert (got[k] === want[k]) else begin
				$display("error: time %0t signal hog_out%0d expected %h actual %h",
					$time, k, want[k], got[k]);
				err_count++;
			end
		end
	endtask

	// one tile per falling edge; an idle tile is all zero at strip 0, column 0
	task automatic step(input bit idle, input int s, input int c);
		hog_pkg::blk_word_t [BLOCKS-1:0] blks;
		out_set_t want;
		@(negedge clk);
		check_outputs();
		blks = '0;
		want = '0;
		if (!idle) begin
			for (int k = 0; k < BLOCKS; k++) begin
				for (int r = 0; r < DIM; r++) begin
					for (int cc = 0; cc < DIM; cc++) begin
						blks[k][8-(r*DIM+cc)] =
							img[DIM*s+r][hog_pkg::TILE_COLS*c+DIM*k+cc];
					end
				end
			end
			want = expected_tile(s, c);
		end
		cnt_row = idle ? '0 : s[hog_pkg::ROW_CNT_W-1:0];
		cnt_col = idle ? '0 : c[COL_W-1:0];
		block0 = blks[0];
		block1 = blks[1];
		block2 = blks[2];
		block3 = blks[3];
		exp_q.push_back(want);
	endtask

	// random tile and counters on the inputs, same time step as the last drive
	task automatic drive_noise();
		hog_pkg::blk_word_t [BLOCKS-1:0] blks;
		logic [7:0] col_bits;
		for (int k = 0; k < BLOCKS; k++) begin
			for (int i = 0; i < hog_pkg::BLK_PIX; i++) begin
				blks[k][i] = random_pixel();
			end
		end
		col_bits = random_pixel();
		cnt_row = random_pixel();
		cnt_col = col_bits[COL_W-1:0];
		block0 = blks[0];
		block1 = blks[1];
		block2 = blks[2];
		block3 = blks[3];
	endtask

	task automatic fill_image(input int strips);
		for (int y = 0; y < strips * DIM; y++) begin
			for (int x = 0; x < IMG_W; x++) begin
				img[y][x] = random_pixel();
			end
		end
	endtask

	// tiles go strip by strip with no gap, as the line store expects
	task automatic run_image(input int strips);
		fill_image(strips);
		for (int s = 0; s < strips; s++) begin
			for (int c = 0; c < LINE_TILES; c++) begin
				step(1'b0, s, c);
			end
		end
	endtask

	task automatic end_test(input int num, input string name, input int err_before);
		repeat (LATENCY) step(1'b1, 0, 0);
		if (err_count == err_before) begin
			pass_count++;
			$display("test %0d %s: pass", num, name);
		end else begin
			fail_count++;
			$display("test %0d %s: fail with %0d mismatches", num, name,
				err_count - err_before);
		end
	endtask

	initial begin
		int mark;
		void'($urandom(32'hfdbb));
		rst_n = 1'b0;
		cnt_row = '0;
		cnt_col = '0;
		block0 = '0;
		block1 = '0;
		block2 = '0;
		block3 = '0;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		// outputs read zero from the first edge in reset
		repeat (LATENCY) exp_q.push_back('0);

		mark = err_count;
		// live tiles during reset must not reach the outputs
		repeat (4) begin
			step(1'b1, 0, 0);
			drive_noise();
		end
		step(1'b1, 0, 0);
		rst_n = 1'b1;
		end_test(1, "reset clears outputs", mark);

		mark = err_count;
		fill_image(1);
		step(1'b0, 0, 0);
		end_test(2, "single corner tile", mark);

		mark = err_count;
		run_image(1);
		end_test(3, "gx across tiles and blocks", mark);

		mark = err_count;
		run_image(2);
		end_test(4, "gy from the saved bottom row", mark);

		// second image right behind the first, store still holds old rows
		mark = err_count;
		run_image(2);
		run_image(2);
		end_test(5, "strip and image restart", mark);

		mark = err_count;
		repeat (RAND_IMAGES) run_image(MAX_STRIPS);
		end_test(6, "back to back random images", mark);

		$display("summary: %0d tests, %0d passed, %0d failed, %0d mismatches",
			pass_count + fail_count, pass_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#((TOTAL_TILES + 50) * PERIOD);
		$display("timeout: the tile sequence did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
hog_pkg.sv
hog_line_if.sv
hog_grad_if.sv
hog_line_store.sv
hog_gradient.sv
hog_magnitude.sv
hog_top.sv
tb_hog.sv
